// ==== src/invadersPkg.sv ====
/*
 * Invaders shared definitions
 * Move command, colour codes and the default 640x480 raster
 */
`default_nettype none

package invadersPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Move stream and colour types
   ////////////////////////////////////////////////////////////////////////////

   // One step of the ship, one bit wide
   typedef enum logic [0:0] {
      moveLeft  = 1'b0,
      moveRight = 1'b1
   } moveT;

   typedef logic [2:0] colorT;                // Red in bit 2, blue in bit 0

   localparam colorT colorBlack = 3'b000;     // Background and blanking
   localparam colorT colorGreen = 3'b010;     // Invader row
   localparam colorT colorWhite = 3'b111;     // Ship

   ////////////////////////////////////////////////////////////////////////////
   // Default raster, 640x480 at 60 Hz with a 25 MHz pixel clock
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [9:0] defHActive    = 10'd640;
   localparam logic [9:0] defHSyncStart = 10'd656;   // After front porch
   localparam logic [9:0] defHSyncEnd   = 10'd752;
   localparam logic [9:0] defHTotal     = 10'd800;

   localparam logic [9:0] defVActive    = 10'd480;
   localparam logic [9:0] defVSyncStart = 10'd490;
   localparam logic [9:0] defVSyncEnd   = 10'd492;
   localparam logic [9:0] defVTotal     = 10'd525;

   localparam int defCellShift = 5;           // 32 pixel cells, 20 x 15 grid

   // Stable samples before a button counts, about 2 ms at 25 MHz
   localparam logic [15:0] defDebounce = 16'd50000;

endpackage

`default_nettype wire

// ==== src/pixelIf.sv ====
/*
 * Raster link
 * Pixel position, blanking and raw syncs from the timing generator
 */
`timescale 1ns/1ps
`default_nettype none

interface pixelIf;
   logic [9:0] x;           // Pixel column
   logic [9:0] y;           // Scan line
   logic       active;      // Inside visible area
   logic       hsyncRaw;    // Active low
   logic       vsyncRaw;    // Active low
   logic       frameStart;  // Single cycle at (0,0)

   // Generator side
   modport timing (output x, y, active, hsyncRaw, vsyncRaw, frameStart);

   // Pixel colouring side
   modport render (input x, y, active, hsyncRaw, vsyncRaw);

   // Frame tick only, for game state updates
   modport frame (input frameStart);
endinterface

`default_nettype wire

// ==== src/vgaTiming.sv ====
/*
 * VGA raster timing
 * Free running pixel and line counters with sync, blanking and frame tick
 */
`timescale 1ns/1ps
`default_nettype none

module vgaTiming #(
   parameter logic [9:0] hActive    = invadersPkg::defHActive,
   parameter logic [9:0] hSyncStart = invadersPkg::defHSyncStart,
   parameter logic [9:0] hSyncEnd   = invadersPkg::defHSyncEnd,
   parameter logic [9:0] hTotal     = invadersPkg::defHTotal,
   parameter logic [9:0] vActive    = invadersPkg::defVActive,
   parameter logic [9:0] vSyncStart = invadersPkg::defVSyncStart,
   parameter logic [9:0] vSyncEnd   = invadersPkg::defVSyncEnd,
   parameter logic [9:0] vTotal     = invadersPkg::defVTotal
) (
   input  logic   dclk,
   input  logic   rstN,
   pixelIf.timing pix
);

   logic [9:0] hCount;       // Pixel within line
   logic [9:0] vCount;       // Line within frame
   logic       lineEnd;
   logic       frameEnd;

   assign lineEnd  = (hCount == hTotal - 10'd1);
   assign frameEnd = (vCount == vTotal - 10'd1);

   // Counters advance every clock, vertical steps at line wrap
   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         hCount <= '0;
         vCount <= '0;
      end else if (lineEnd) begin
         hCount <= '0;
         vCount <= frameEnd ? 10'd0 : vCount + 10'd1;
      end else begin
         hCount <= hCount + 10'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Decode from the counts
   ////////////////////////////////////////////////////////////////////////////

   assign pix.x          = hCount;
   assign pix.y          = vCount;
   assign pix.active     = (hCount < hActive) && (vCount < vActive);
   assign pix.hsyncRaw   = !((hCount >= hSyncStart) && (hCount < hSyncEnd));  // Low in window
   assign pix.vsyncRaw   = !((vCount >= vSyncStart) && (vCount < vSyncEnd));
   assign pix.frameStart = (hCount == 10'd0) && (vCount == 10'd0);

endmodule

`default_nettype wire

// ==== src/edgeDetectorDebounce.sv ====
/*
 * Button debouncer
 * Synchronises one button and pulses once per debounced press
 */
`timescale 1ns/1ps
`default_nettype none

module edgeDetectorDebounce #(
   parameter logic [15:0] debounceLen = invadersPkg::defDebounce
) (
   input  logic dclk,
   input  logic rstN,
   input  logic in,
   output logic detected
);

   logic [1:0]  syncQ;       // Two flop synchroniser
   logic        level;       // Synchronised button
   logic        state;       // Debounced button
   logic [15:0] stableCnt;   // Samples differing from state
   logic        settle;      // Level held long enough

   assign level  = syncQ[1];
   assign settle = (level != state) && (stableCnt == debounceLen - 16'd1);

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         syncQ <= '0;
      end else begin
         syncQ <= {syncQ[0], in};
      end
   end

   // Any bounce back to state restarts the count
   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         state     <= 1'b0;
         stableCnt <= '0;
         detected  <= 1'b0;
      end else begin
         detected <= settle && level;   // Rising edge of debounced state only
         if (level == state) begin
            stableCnt <= '0;
         end else if (settle) begin
            state     <= level;
            stableCnt <= '0;
         end else begin
            stableCnt <= stableCnt + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/buttonPad.sv ====
/*
 * Button pad
 * Debounces left and right and offers one pending move at a time
 */
`timescale 1ns/1ps
`default_nettype none

module buttonPad #(
   parameter logic [15:0] debounceLen = invadersPkg::defDebounce
) (
   input  logic              dclk,
   input  logic              rstN,
   input  logic              left,
   input  logic              right,
   output logic              moveValid,
   input  logic              moveReady,
   output invadersPkg::moveT moveDir
);

   logic leftHit;            // Debounced press pulses
   logic rightHit;

   edgeDetectorDebounce #(.debounceLen(debounceLen)) leftDetector (
      .dclk     (dclk),
      .rstN     (rstN),
      .in       (left),
      .detected (leftHit)
   );

   edgeDetectorDebounce #(.debounceLen(debounceLen)) rightDetector (
      .dclk     (dclk),
      .rstN     (rstN),
      .in       (right),
      .detected (rightHit)
   );

   // Pending flag, presses while pending are lost
   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         moveValid <= 1'b0;
      end else if (moveValid) begin
         if (moveReady) moveValid <= 1'b0;   // Transfer done
      end else if (leftHit || rightHit) begin
         moveValid <= 1'b1;
      end
   end

   // Direction held stable while pending, left wins a tie
   always_ff @(posedge dclk) begin
      if (!moveValid && (leftHit || rightHit)) begin
         moveDir <= leftHit ? invadersPkg::moveLeft : invadersPkg::moveRight;
      end
   end

endmodule

`default_nettype wire

// ==== src/moveFifo.sv ====
/*
 * Move command FIFO
 * Small circular buffer between the button pad and the ship
 */
`timescale 1ns/1ps
`default_nettype none

module moveFifo #(
   parameter int fifoDepth = 4
) (
   input  logic              dclk,
   input  logic              rstN,
   input  logic              inValid,
   output logic              inReady,
   input  invadersPkg::moveT inDir,
   output logic              outValid,
   input  logic              outReady,
   output invadersPkg::moveT outDir
);

   localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

   invadersPkg::moveT mem [fifoDepth];   // Entry storage

   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [ptrW:0]   count;               // Occupancy, 0 to fifoDepth
   logic            push;
   logic            pop;

   assign inReady  = (count != (ptrW+1)'(fifoDepth));   // Low when full
   assign outValid = (count != '0);
   assign outDir   = mem[rdPtr];                       // Head entry
   assign push     = inValid && inReady;
   assign pop      = outValid && outReady;

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
         end
         if (push && !pop)      count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge dclk) begin
      if (push) mem[wrPtr] <= inDir;
   end

endmodule

`default_nettype wire

// ==== src/ship.sv ====
/*
 * Ship controller
 * Column register stepped by at most one queued move per frame
 */
`timescale 1ns/1ps
`default_nettype none

module ship #(
   parameter logic [9:0] hActive   = invadersPkg::defHActive,
   parameter int         cellShift = invadersPkg::defCellShift
) (
   input  logic              dclk,
   input  logic              rstN,
   pixelIf.frame             frame,
   input  logic              shipValid,
   output logic              shipReady,
   input  invadersPkg::moveT shipDir,
   output logic [4:0]        posH
);

   // Rightmost cell column of the grid
   localparam logic [9:0] numCols = hActive >> cellShift;
   localparam logic [4:0] lastCol = 5'(numCols - 10'd1);

   logic take;               // Move accepted this cycle

   assign shipReady = frame.frameStart;   // One pop slot per frame
   assign take      = shipValid && shipReady;

   // Updates at pixel (0,0), ship row sees new column all frame
   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         posH <= '0;
      end else if (take) begin
         if (shipDir == invadersPkg::moveLeft) begin
            if (posH != 5'd0) posH <= posH - 5'd1;      // Clamp left edge
         end else begin
            if (posH != lastCol) posH <= posH + 5'd1;   // Clamp right edge
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/formatVGA.sv ====
/*
 * Pixel renderer
 * Colours each pixel from the cell grid and registers it with the syncs
 */
`timescale 1ns/1ps
`default_nettype none

module formatVGA #(
   parameter int cellShift = invadersPkg::defCellShift
) (
   input  logic        dclk,
   input  logic        rstN,
   pixelIf.render      pix,
   input  logic [19:0] invArray,   // One bit per column
   input  logic [3:0]  invLine,    // Invader row
   input  logic [4:0]  shipX,      // Ship column
   output logic        red,
   output logic        green,
   output logic        blue,
   output logic        hsync,
   output logic        vsync
);

   localparam logic [4:0] numCols = 5'd20;   // Grid is 20 x 15 cells
   localparam logic [4:0] lastRow = 5'd14;   // Ship row

   logic [9:0]         colFull;     // x in cells
   logic [9:0]         rowFull;     // y in cells
   logic [4:0]         col;
   logic [4:0]         row;
   logic               invHere;
   logic               shipHere;
   invadersPkg::colorT color;       // Next pixel colour
   invadersPkg::colorT colorQ;

   assign colFull = pix.x >> cellShift;
   assign rowFull = pix.y >> cellShift;
   assign col     = colFull[4:0];
   assign row     = rowFull[4:0];

   // Guard column range so the invArray index stays legal
   assign invHere  = (row == {1'b0, invLine}) && (col < numCols) && invArray[col];
   assign shipHere = (row == lastRow) && (col == shipX);

   ////////////////////////////////////////////////////////////////////////////
   // Colour select, invaders over ship
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (!pix.active)   color = invadersPkg::colorBlack;   // Blanking
      else if (invHere)  color = invadersPkg::colorGreen;
      else if (shipHere) color = invadersPkg::colorWhite;
      else               color = invadersPkg::colorBlack;
   end

   // Colour and syncs share one stage so they line up
   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         colorQ <= invadersPkg::colorBlack;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
      end else begin
         colorQ <= color;
         hsync  <= pix.hsyncRaw;
         vsync  <= pix.vsyncRaw;
      end
   end

   assign red   = colorQ[2];
   assign green = colorQ[1];
   assign blue  = colorQ[0];

endmodule

`default_nettype wire

// ==== src/invadersTop.sv ====
/*
 * Space Invaders display core
 * Raster timing, button driven ship and cell renderer for a VGA monitor
 */
`timescale 1ns/1ps
`default_nettype none

module invadersTop #(
   parameter logic [9:0]  hActive     = invadersPkg::defHActive,
   parameter logic [9:0]  hSyncStart  = invadersPkg::defHSyncStart,
   parameter logic [9:0]  hSyncEnd    = invadersPkg::defHSyncEnd,
   parameter logic [9:0]  hTotal      = invadersPkg::defHTotal,
   parameter logic [9:0]  vActive     = invadersPkg::defVActive,
   parameter logic [9:0]  vSyncStart  = invadersPkg::defVSyncStart,
   parameter logic [9:0]  vSyncEnd    = invadersPkg::defVSyncEnd,
   parameter logic [9:0]  vTotal      = invadersPkg::defVTotal,
   parameter int          cellShift   = invadersPkg::defCellShift,
   parameter logic [15:0] debounceLen = invadersPkg::defDebounce,
   parameter int          fifoDepth   = 4
) (
   input  logic        dclk,       // Pixel clock
   input  logic        rstN,
   input  logic        left,       // Raw buttons
   input  logic        right,
   input  logic [19:0] invArray,
   input  logic [3:0]  invLine,
   output logic        hsync,
   output logic        vsync,
   output logic        red,
   output logic        green,
   output logic        blue
);

   logic              moveValid;   // Pad to FIFO
   logic              moveReady;
   invadersPkg::moveT moveDir;
   logic              shipValid;   // FIFO to ship
   logic              shipReady;
   invadersPkg::moveT shipDir;
   logic [4:0]        posH;        // Ship column

   pixelIf pix ();

   vgaTiming #(
      .hActive (hActive), .hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .hTotal (hTotal),
      .vActive (vActive), .vSyncStart (vSyncStart), .vSyncEnd (vSyncEnd), .vTotal (vTotal)
   ) vgaTiming1 (.dclk (dclk), .rstN (rstN), .pix (pix));

   buttonPad #(.debounceLen (debounceLen)) buttonPad1 (
      .dclk (dclk), .rstN (rstN), .left (left), .right (right),
      .moveValid (moveValid), .moveReady (moveReady), .moveDir (moveDir)
   );

   moveFifo #(.fifoDepth (fifoDepth)) moveFifo1 (
      .dclk (dclk), .rstN (rstN),
      .inValid (moveValid), .inReady (moveReady), .inDir (moveDir),
      .outValid (shipValid), .outReady (shipReady), .outDir (shipDir)
   );

   ship #(.hActive (hActive), .cellShift (cellShift)) ship1 (
      .dclk (dclk), .rstN (rstN), .frame (pix),
      .shipValid (shipValid), .shipReady (shipReady), .shipDir (shipDir), .posH (posH)
   );

   formatVGA #(.cellShift (cellShift)) formatVGA1 (
      .dclk (dclk), .rstN (rstN), .pix (pix),
      .invArray (invArray), .invLine (invLine), .shipX (posH),
      .red (red), .green (green), .blue (blue), .hsync (hsync), .vsync (vsync)
   );

endmodule

`default_nettype wire

// ==== verif/invadersTb.sv ====
/*
 * Invaders display testbench
 * Small raster, table of button presses, full frame pixel and sync check
 */
`timescale 1ns/1ps
`default_nettype none

module invadersTb;

   // Small screen, still a 20 x 15 grid of 4 pixel cells
   localparam logic [9:0]  hAct = 10'd80, hSs = 10'd84, hSe = 10'd90, hTot = 10'd100;
   localparam logic [9:0]  vAct = 10'd60, vSs = 10'd62, vSe = 10'd64, vTot = 10'd66;
   localparam int          cellSh   = 2;
   localparam logic [15:0] debLen   = 16'd8;
   localparam int          frameLen = 100 * 66;
   localparam logic [4:0]  shipRow  = 5'((vAct >> cellSh) - 10'd1);
   localparam int          numTests = 9;

   // Hold of 0 means a glitch of random length
   typedef struct packed {
      logic       isRight;
      logic [7:0] hold;      // Cycles the button stays down
      logic [7:0] reps;      // Presses before the check frame
      logic [3:0] line;      // Invader row
      logic [4:0] col;       // Expected ship column
   } testT;

   localparam testT tests [numTests] = '{
      '{1'b0, 8'd16, 8'd1,  4'd2,  5'd0},    // Left at column 0 clamps
      '{1'b1, 8'd16, 8'd1,  4'd5,  5'd1},
      '{1'b1, 8'd12, 8'd2,  4'd0,  5'd3},
      '{1'b0, 8'd20, 8'd1,  4'd7,  5'd2},
      '{1'b1, 8'd0,  8'd1,  4'd3,  5'd2},    // Glitch, no move
      '{1'b1, 8'd16, 8'd20, 4'd10, 5'd19},   // Runs into right edge
      '{1'b0, 8'd0,  8'd2,  4'd13, 5'd19},
      '{1'b0, 8'd16, 8'd1,  4'd1,  5'd18},
      '{1'b1, 8'd14, 8'd3,  4'd12, 5'd19}
   };

   logic        dclk;
   logic        rstN;
   logic        left;
   logic        right;
   logic [19:0] invArray;
   logic [3:0]  invLine;
   logic        hsync, vsync, red, green, blue;

   logic [9:0]  mx, my;       // Model raster position
   logic [9:0]  ox, oy;       // Position shown at the ports
   logic [31:0] seed;
   int          errCount;
   int          failedTests;
   int          cycleCount = 0;
   int          cycleLimit = 0;

   invadersTop #(
      .hActive (hAct), .hSyncStart (hSs), .hSyncEnd (hSe), .hTotal (hTot),
      .vActive (vAct), .vSyncStart (vSs), .vSyncEnd (vSe), .vTotal (vTot),
      .cellShift (cellSh), .debounceLen (debLen), .fifoDepth (4)
   ) u_invadersTop (
      .dclk (dclk), .rstN (rstN), .left (left), .right (right),
      .invArray (invArray), .invLine (invLine),
      .hsync (hsync), .vsync (vsync), .red (red), .green (green), .blue (blue)
   );

   always #5 dclk = ~dclk;

   // Raster model, ports lag the counts by the output register
   always @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         mx <= '0;
         my <= '0;
         ox <= '0;
         oy <= '0;
      end else begin
         ox <= mx;
         oy <= my;
         if (mx == hTot - 10'd1) begin
            mx <= '0;
            my <= (my == vTot - 10'd1) ? 10'd0 : my + 10'd1;
         end else begin
            mx <= mx + 10'd1;
         end
      end
   end

   always @(posedge dclk) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("Timeout: run still busy after %0d cycles", cycleCount);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic logic [31:0] nextRand(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Invaders drawn over the ship, blanking black
   function automatic logic [2:0] pixelColor(input logic [9:0] px, input logic [9:0] py,
                                             input logic [19:0] inv, input logic [3:0] line,
                                             input logic [4:0] shipCol);
      logic [4:0] c;
      logic [4:0] r;
      c = 5'(px >> cellSh);
      r = 5'(py >> cellSh);
      if (px >= hAct || py >= vAct) return invadersPkg::colorBlack;
      if (r == {1'b0, line} && inv[c]) return invadersPkg::colorGreen;
      if (r == shipRow && c == shipCol) return invadersPkg::colorWhite;
      return invadersPkg::colorBlack;
   endfunction

   task automatic checkResetState();
      assert (hsync === 1'b1) else begin
         $display("ERR hsync in reset exp %h got %h", 1'b1, hsync);
         errCount++;
      end
      assert (vsync === 1'b1) else begin
         $display("ERR vsync in reset exp %h got %h", 1'b1, vsync);
         errCount++;
      end
      assert ({red, green, blue} === 3'b000) else begin
         $display("ERR rgb in reset exp %h got %h", 3'b000, {red, green, blue});
         errCount++;
      end
   endtask

   task automatic pressButton(input logic isRight, input int cycles);
      @(posedge dclk);
      #1;
      left  = !isRight;
      right = isRight;
      repeat (cycles) @(posedge dclk);
      #1;
      left  = 1'b0;
      right = 1'b0;
   endtask

   // First pixel of a frame appears at the ports
   task automatic waitFrameStarts(input int n);
      for (int k = 0; k < n; k++) begin
         do begin
            @(posedge dclk);
            #1;
         end while (!(ox == 10'd0 && oy == 10'd0));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One whole frame against the model, sampled on falling edges
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkFrame(input logic [19:0] inv, input logic [3:0] line,
                             input logic [4:0] shipCol);
      logic [2:0] expRgb;
      logic       expH;
      logic       expV;
      for (int i = 0; i < frameLen; i++) begin
         @(negedge dclk);
         expRgb = pixelColor(ox, oy, inv, line, shipCol);
         expH   = !(ox >= hSs && ox < hSe);   // Active low windows
         expV   = !(oy >= vSs && oy < vSe);
         assert (hsync === expH) else begin
            $display("ERR hsync exp %h got %h at x %0d y %0d", expH, hsync, ox, oy);
            errCount++;
         end
         assert (vsync === expV) else begin
            $display("ERR vsync exp %h got %h at x %0d y %0d", expV, vsync, ox, oy);
            errCount++;
         end
         assert ({red, green, blue} === expRgb) else begin
            $display("ERR rgb exp %h got %h at x %0d y %0d", expRgb, {red, green, blue}, ox, oy);
            errCount++;
         end
      end
   endtask

   initial begin
      int         baseErr;
      int         glitchLen;
      int         totalReps;
      logic [19:0] inv;
      dclk        = 1'b0;
      rstN        = 1'b0;
      left        = 1'b0;
      right       = 1'b0;
      invArray    = '0;
      invLine     = '0;
      errCount    = 0;
      failedTests = 0;
      seed        = 32'h5a90_4e81;
      totalReps   = 0;
      for (int t = 0; t < numTests; t++) totalReps += int'(tests[t].reps);
      // Up to two frames per press, one check frame per test, plus slack
      cycleLimit = (totalReps * 3 + numTests * 2 + 4) * frameLen;

      for (int i = 0; i < 3; i++) begin
         @(posedge dclk);
         #1;
         checkResetState();
      end
      rstN = 1'b1;
      repeat (2) @(negedge dclk);
      checkResetState();             // First pixel out of reset, still blank

      for (int t = 0; t < numTests; t++) begin
         baseErr = errCount;
         seed    = nextRand(seed);
         inv     = seed[31:12];
         @(posedge dclk);
         #1;
         invArray = inv;
         invLine  = tests[t].line;
         for (int r = 0; r < int'(tests[t].reps); r++) begin
            if (tests[t].hold == 8'd0) begin
               seed      = nextRand(seed);
               glitchLen = 1 + int'(seed[23:16]) % (int'(debLen) - 2);
               pressButton(tests[t].isRight, glitchLen);
            end else begin
               pressButton(tests[t].isRight, int'(tests[t].hold));
            end
            waitFrameStarts(2);
         end
         checkFrame(inv, tests[t].line, tests[t].col);
         if (errCount == baseErr) begin
            $display("test %0d pass, ship col %0d", t, tests[t].col);
         end else begin
            $display("test %0d fail, %0d errors", t, errCount - baseErr);
            failedTests++;
         end
      end

      $display("tests %0d, failed %0d, errors %0d", numTests, failedTests, errCount);
      if (errCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
src/invadersPkg.sv
src/pixelIf.sv
src/vgaTiming.sv
src/edgeDetectorDebounce.sv
src/buttonPad.sv
src/moveFifo.sv
src/ship.sv
src/formatVGA.sv
src/invadersTop.sv
verif/invadersTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the Verilator model from list.f, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f list.f --top-module invadersTb &&
out=$(./obj_dir/VinvadersTb) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
